//--- design/busPkg.sv
package busPkg;

   // byte address and response beat widths
   parameter int addrWidth = 64;
   parameter int dataWidth = 64;

   // one 8-byte beat per response cycle
   parameter int beatBytes = 8;

   // a read request always returns a full line
   parameter int lineBytes = 64;

   // tag layout is direction bit, then target code, then spare bits
   parameter int tagWidth = 13;

   parameter logic reqRead = 1'b1;

   parameter logic [3:0] targetMemory = 4'b0001;

endpackage

//--- design/fetchFrontEnd.sv
module fetchFrontEnd #(
   parameter int bufferBytes = 128,
   parameter int refillLevel = 32
) (
   input  logic                                bus,
   input  logic                                reset,
   input  logic [busPkg::addrWidth-1:0]        entry,
   input  logic                                reqAck,
   input  logic                                respCyc,
   input  logic [busPkg::dataWidth-1:0]        resp,
   input  logic [3:0]                          consume,
   output logic                                reqCyc,
   output logic [busPkg::addrWidth-1:0]        req,
   output logic [busPkg::tagWidth-1:0]         reqTag,
   output logic                                respAck,
   output logic [fetchPkg::maxInstBytes*8-1:0] window,
   output logic                                windowValid,
   output logic [busPkg::addrWidth-1:0]        windowRip
);
   import busPkg::*;

   logic                 beatValid;
   logic [dataWidth-1:0] beatData;
   logic                 hasRoom;

   // every response beat is taken
   assign respAck = respCyc;

   fetchRequester u_fetchRequester (
      .bus       (bus),
      .reset     (reset),
      .entry     (entry),
      .hasRoom   (hasRoom),
      .reqAck    (reqAck),
      .respCyc   (respCyc),
      .resp      (resp),
      .reqCyc    (reqCyc),
      .req       (req),
      .reqTag    (reqTag),
      .beatValid (beatValid),
      .beatData  (beatData)
   );

   instByteBuffer #(
      .bufferBytes (bufferBytes),
      .refillLevel (refillLevel)
   ) u_instByteBuffer (
      .bus         (bus),
      .reset       (reset),
      .entry       (entry),
      .beatValid   (beatValid),
      .beatData    (beatData),
      .consume     (consume),
      .hasRoom     (hasRoom),
      .window      (window),
      .windowValid (windowValid),
      .windowRip   (windowRip)
   );

endmodule

//--- design/fetchPkg.sv
package fetchPkg;

   // progress of the single outstanding line request
   typedef enum logic [1:0] {
      fetchIdle,
      fetchWaiting,
      fetchActive
   } fetchState;

   // longest legal x86 instruction
   parameter int maxInstBytes = 15;

endpackage

//--- design/fetchRequester.sv
module fetchRequester (
   input  logic                         bus,
   input  logic                         reset,
   input  logic [busPkg::addrWidth-1:0] entry,
   input  logic                         hasRoom,
   input  logic                         reqAck,
   input  logic                         respCyc,
   input  logic [busPkg::dataWidth-1:0] resp,
   output logic                         reqCyc,
   output logic [busPkg::addrWidth-1:0] req,
   output logic [busPkg::tagWidth-1:0]  reqTag,
   output logic                         beatValid,
   output logic [busPkg::dataWidth-1:0] beatData
);
   import busPkg::*;
   import fetchPkg::*;

   localparam int beatShift = $clog2(beatBytes);
   localparam int lineShift = $clog2(lineBytes);
   localparam int skipWidth = lineShift - beatShift;
   localparam int tagPad    = tagWidth - 1 - $bits(targetMemory);

   fetchState state;

   // next beat address, its beat bits double as the beat counter
   logic [addrWidth-1:0] fetchAddr;

   // beats still to drop before the entry beat
   logic [skipWidth-1:0] skipCount;

   logic sendReq;
   logic lastBeat;

   // only one line in flight, and never while an ack is pending
   assign sendReq = (state == fetchIdle) && hasRoom && !reqAck;

   assign lastBeat = (fetchAddr[lineShift-1:beatShift] == '1);

   // beats ahead of the entry beat never reach the buffer
   assign beatValid = respCyc && (skipCount == '0);
   assign beatData  = resp;

   always_ff @(posedge bus) begin
      if (reset) begin
         state     <= fetchIdle;
         reqCyc    <= 1'b0;
         fetchAddr <= {entry[addrWidth-1:lineShift], {lineShift{1'b0}}};
         skipCount <= entry[lineShift-1:beatShift];
      end else begin
         reqCyc <= sendReq;

         if (respCyc) begin
            fetchAddr <= fetchAddr + addrWidth'(beatBytes);
            if (skipCount != '0) begin
               skipCount <= skipCount - 1'b1;
            end
            // idle again once the eighth beat of the line is in
            if (lastBeat) begin
               state <= fetchIdle;
            end else begin
               state <= fetchActive;
            end
         end else if ((state == fetchIdle) && reqAck) begin
            state <= fetchWaiting;
         end
      end
   end

   // request address and tag follow the fetch address
   always_ff @(posedge bus) begin
      req    <= {fetchAddr[addrWidth-1:lineShift], {lineShift{1'b0}}};
      reqTag <= {reqRead, targetMemory, {tagPad{1'b0}}};
   end

endmodule

//--- design/instByteBuffer.sv
module instByteBuffer #(
   parameter int bufferBytes = 128,
   parameter int refillLevel = 32
) (
   input  logic                                bus,
   input  logic                                reset,
   input  logic [busPkg::addrWidth-1:0]        entry,
   input  logic                                beatValid,
   input  logic [busPkg::dataWidth-1:0]        beatData,
   input  logic [3:0]                          consume,
   output logic                                hasRoom,
   output logic [fetchPkg::maxInstBytes*8-1:0] window,
   output logic                                windowValid,
   output logic [busPkg::addrWidth-1:0]        windowRip
);
   import busPkg::*;
   import fetchPkg::*;

   localparam int ptrWidth  = $clog2(bufferBytes);
   localparam int cntWidth  = ptrWidth + 1;
   localparam int beatShift = $clog2(beatBytes);

   logic [7:0] store [bufferBytes];

   // pointers carry one extra bit
   // so a decode offset still ahead of the first write reads as a negative level
   logic [cntWidth-1:0] fillPtr;
   logic [cntWidth-1:0] decodePtr;

   logic signed [cntWidth-1:0] level;

   logic [ptrWidth-1:0] fillIdx;
   logic [ptrWidth-1:0] decodeIdx;

   assign fillIdx   = fillPtr[ptrWidth-1:0];
   assign decodeIdx = decodePtr[ptrWidth-1:0];

   // bytes buffered ahead of the decode offset
   assign level = fillPtr - decodePtr;

   assign windowValid = (level >= maxInstBytes);
   assign hasRoom     = (level < refillLevel);

   // window byte i sits at bits 8*i and up, wrapping past the end of the store
   always_comb begin
      logic [ptrWidth-1:0] idx;
      for (int i = 0; i < maxInstBytes; i++) begin
         idx = decodeIdx + ptrWidth'(i);
         window[8*i +: 8] = store[idx];
      end
   end

   // beats land little endian at the fill offset
   always_ff @(posedge bus) begin
      if (beatValid) begin
         for (int b = 0; b < beatBytes; b++) begin
            store[fillIdx + ptrWidth'(b)] <= beatData[8*b +: 8];
         end
      end
   end

   always_ff @(posedge bus) begin
      if (reset) begin
         fillPtr   <= '0;
         // first kept beat is written at offset 0
         decodePtr <= cntWidth'(entry[beatShift-1:0]);
         windowRip <= entry;
      end else begin
         if (beatValid) begin
            fillPtr <= fillPtr + cntWidth'(beatBytes);
         end
         // decoder count only counts against a full window
         if (windowValid) begin
            decodePtr <= decodePtr + cntWidth'(consume);
            windowRip <= windowRip + addrWidth'(consume);
         end
      end
   end

endmodule

//--- flist.f
design/busPkg.sv
design/fetchPkg.sv
design/fetchRequester.sv
design/instByteBuffer.sv
design/fetchFrontEnd.sv
tb/memoryResponder.sv
tb/tbFetchFrontEnd.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module tbFetchFrontEnd \
   -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qF "*** FAILED ***" sim.log; then
   exit 1
fi
exit 0

//--- tb/fetchPatterns.hex
// word 0 is the memory image key, folded into every image byte
// then one record per test as three words:
//   entry address, consume mode, expected final window address
// consume mode 0 = fixed steps 1 to 15, 1 = random steps, 2 = mostly stalled
0000000000a5c3e1
// unaligned entry, fixed steps
0000000000001003
0000000000000000
0000000000001063
// long random stream across many buffer wraps
000000000002002d
0000000000000001
000000000002017d
// aligned entry, long decoder and memory stalls
0000000000003000
0000000000000002
0000000000003080
// entry near a 32-bit boundary
00000000ffffffc6
0000000000000001
0000000100000026
// unaligned entry late in its line
0000000000004039
0000000000000000
00000000000040b9

//--- tb/memoryResponder.sv
module memoryResponder (
   input  logic        bus,
   input  logic        reset,
   input  logic        stall,
   input  logic [63:0] imageKey,
   input  logic        reqCyc,
   input  logic [63:0] req,
   output logic        reqAck,
   output logic        respCyc,
   output logic [63:0] resp
);
   timeunit 1ns;
   timeprecision 100ps;

   logic        busy;
   logic        inReset;
   logic [63:0] lineAddr;
   int          beatIdx;

   // image byte is a weighted fold of all eight address bytes
   function automatic logic [7:0] byteAt(input logic [63:0] addr);
      logic [7:0] acc;
      acc = imageKey[7:0];
      for (int k = 0; k < 8; k++) begin
         acc = acc + addr[8*k +: 8] * 8'(k + 1);
      end
      return acc;
   endfunction

   initial begin
      reqAck  = 1'b0;
      respCyc = 1'b0;
      resp    = '0;
      busy    = 1'b0;
   end

   // reset is sampled at the edge, bus outputs change 2 ns later
   always @(posedge bus) begin
      inReset = reset;
      #2;
      reqAck  = 1'b0;
      respCyc = 1'b0;
      if (inReset) begin
         busy = 1'b0;
      end else if (!busy) begin
         if (reqCyc && !stall) begin
            reqAck   = 1'b1;
            busy     = 1'b1;
            lineAddr = req;
            beatIdx  = 0;
         end
      end else if (!stall) begin
         respCyc = 1'b1;
         for (int i = 0; i < 8; i++) begin
            resp[8*i +: 8] = byteAt(lineAddr + 64'(8 * beatIdx + i));
         end
         beatIdx++;
         if (beatIdx == 8) begin
            busy = 1'b0;
         end
      end
   end

endmodule

//--- tb/tbFetchFrontEnd.sv
module tbFetchFrontEnd;
   timeunit 1ns;
   timeprecision 100ps;

   import busPkg::*;
   import fetchPkg::*;

   localparam int bufferBytes  = 128;
   localparam int refillLevel  = 32;
   localparam int testCount    = 5;
   localparam int cyclesPerByte = 40;
   localparam logic [31:0] lfsrSeed = 32'h04bad363;

   logic         bus;
   logic         reset;
   logic [63:0]  entry;
   logic         reqAck;
   logic         respCyc;
   logic [63:0]  resp;
   logic [3:0]   consume;
   logic         reqCyc;
   logic [63:0]  req;
   logic [tagWidth-1:0] reqTag;
   logic         respAck;
   logic [maxInstBytes*8-1:0] window;
   logic         windowValid;
   logic [63:0]  windowRip;
   logic         stall;
   logic [63:0]  imageKey;

   logic [63:0]  patterns [1 + 3*testCount];
   logic [31:0]  lfsrState;
   int           errorCount;
   int           checkCount;
   int           cycleCount;
   int           cycleLimit;

   fetchFrontEnd #(
      .bufferBytes (bufferBytes),
      .refillLevel (refillLevel)
   ) u_fetchFrontEnd (
      .bus         (bus),
      .reset       (reset),
      .entry       (entry),
      .reqAck      (reqAck),
      .respCyc     (respCyc),
      .resp        (resp),
      .consume     (consume),
      .reqCyc      (reqCyc),
      .req         (req),
      .reqTag      (reqTag),
      .respAck     (respAck),
      .window      (window),
      .windowValid (windowValid),
      .windowRip   (windowRip)
   );

   memoryResponder u_memoryResponder (
      .bus      (bus),
      .reset    (reset),
      .stall    (stall),
      .imageKey (imageKey),
      .reqCyc   (reqCyc),
      .req      (req),
      .reqAck   (reqAck),
      .respCyc  (respCyc),
      .resp     (resp)
   );

   initial begin
      bus = 1'b0;
      forever #10 bus = ~bus;
   end

   always @(posedge bus) begin
      cycleCount++;
      if (cycleLimit > 0 && cycleCount > cycleLimit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic nextBit();
      logic fb;
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] randomBits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v = {v[30:0], nextBit()};
      end
      return v;
   endfunction

   function automatic logic [7:0] imageByte(input logic [63:0] addr);
      logic [7:0] acc;
      acc = imageKey[7:0];
      for (int k = 0; k < 8; k++) begin
         acc = acc + addr[8*k +: 8] * 8'(k + 1);
      end
      return acc;
   endfunction

   task automatic compareValue(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
      checkCount++;
      if (got !== expected) begin
         errorCount++;
         $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   task automatic resetDut(input logic [63:0] entryAddr);
      @(posedge bus);
      #2;
      reset   = 1'b1;
      entry   = entryAddr;
      consume = 4'd0;
      repeat (16) begin
         @(posedge bus);
         #1;
         compareValue(64'(reqCyc), 64'd0, "reqCyc in reset");
         compareValue(64'(windowValid), 64'd0, "windowValid in reset");
      end
      #1;
      reset = 1'b0;
   endtask

   initial begin
      logic [63:0] entryAddr;
      logic [63:0] mode;
      logic [63:0] finalRip;
      logic [63:0] expRip;
      logic [63:0] remaining;
      logic [3:0]  step;
      logic        firstSeen;
      logic        inFlight;
      int          beatNo;
      int          lineNo;
      int          keptBeats;
      int          stepNo;
      longint      buffered;
      longint      totalBytes;

      reset      = 1'b1;
      entry      = '0;
      consume    = 4'd0;
      stall      = 1'b0;
      errorCount = 0;
      checkCount = 0;
      cycleCount = 0;
      cycleLimit = 0;
      lfsrState  = lfsrSeed;
      $readmemh("tb/fetchPatterns.hex", patterns);
      imageKey = patterns[0];

      totalBytes = 0;
      for (int t = 0; t < testCount; t++) begin
         totalBytes += longint'(patterns[3*t + 3] - patterns[3*t + 1]);
      end
      cycleLimit = int'(totalBytes) * cyclesPerByte;

      for (int t = 0; t < testCount; t++) begin
         entryAddr = patterns[3*t + 1];
         mode      = patterns[3*t + 2];
         finalRip  = patterns[3*t + 3];
         expRip    = entryAddr;
         firstSeen = 1'b0;
         inFlight  = 1'b0;
         beatNo    = 0;
         lineNo    = 0;
         keptBeats = 0;
         stepNo    = 0;
         resetDut(entryAddr);

         // one pass per cycle until the final address is reached
         forever begin
            @(posedge bus);
            #1;
            compareValue(64'(respAck), 64'(respCyc), "respAck");
            if (reqCyc && !firstSeen) begin
               firstSeen = 1'b1;
               compareValue(req, {entryAddr[63:6], 6'b0}, "first request address");
               compareValue(64'(reqTag[12]), 64'(reqRead), "tag read code");
               compareValue(64'(reqTag[11:8]), 64'(targetMemory), "tag target");
            end
            if (reqAck) begin
               inFlight = 1'b1;
               beatNo   = 0;
            end
            if (respCyc) begin
               if (lineNo > 0 || beatNo >= int'(entryAddr[5:3])) begin
                  keptBeats++;
               end
               beatNo++;
               if (beatNo == 8) begin
                  inFlight = 1'b0;
                  lineNo++;
               end
            end
            if (inFlight && reqCyc) begin
               errorCount++;
               $display("Request raised while a line was still in flight");
            end
            compareValue(windowRip, expRip, "windowRip");
            buffered = longint'(keptBeats * 8) - longint'(entryAddr[2:0])
                       - longint'(expRip - entryAddr);
            compareValue(64'(windowValid), 64'(buffered >= maxInstBytes), "windowValid");
            if (windowValid) begin
               for (int i = 0; i < maxInstBytes; i++) begin
                  compareValue(64'(window[8*i +: 8]), 64'(imageByte(expRip + 64'(i))),
                               $sformatf("window byte %0d", i));
               end
            end
            if (buffered > refillLevel + lineBytes) begin
               errorCount++;
               $display("Buffer holds %0d bytes, more than the refill limit allows", buffered);
            end
            if (expRip == finalRip) begin
               break;
            end

            // long memory stalls in mode 2 and short ones otherwise
            if (mode == 64'd2) begin
               stall = (randomBits(2) != 0);
            end else begin
               stall = (randomBits(2) == 0);
            end
            remaining = finalRip - expRip;
            if (mode == 64'd0) begin
               step = 4'(1 + stepNo % 15);
            end else if (mode == 64'd2 && randomBits(3) != 0) begin
               step = 4'd0;
            end else begin
               step = 4'(randomBits(4));
            end
            if (64'(step) > remaining) begin
               step = 4'(remaining);
            end
            #1;
            consume = step;
            if (windowValid) begin
               expRip = expRip + 64'(step);
               stepNo++;
            end
         end
         #1;
         consume = 4'd0;
         // address holds once the decoder stops consuming
         @(posedge bus);
         #1;
         compareValue(windowRip, finalRip, "final windowRip");
      end

      $display("checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule
